//--- logic/decoder_defines.svh
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// instruction word width, 16-bit subset only
`define INSTR_W 16

// register selector, codes 0x00-0x3F are general registers
`define REG_W 7

// immediate, one bit wider than a word so sign survives
`define IMM_W 33

// uIxt extension field
`define IXT_W 8

// micro-ops the consumer can hold before it must free one
`define DEC_CREDITS 4

`endif

//--- logic/decodePkg.sv
`include "decoder_defines.svh"

package decodePkg;

	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`REG_W-1:0] regId_t;
	typedef logic [`IMM_W-1:0] imm_t;
	typedef logic [`IXT_W-1:0] uIxt_t;
	// wide enough to hold the full credit count
	typedef logic [$clog2(`DEC_CREDITS + 1)-1:0] credit_t;

	// special register codes
	localparam regId_t regPc = 7'h40;
	localparam regId_t regGbr = 7'h41;
	localparam regId_t regDlr = 7'h50;
	localparam regId_t regImm = 7'h5E;
	localparam regId_t regZzr = 7'h5F;

	typedef enum logic [7:0] {
		NOP, INVOP,
		MOVB_RM, MOVW_RM, MOVL_RM, MOVQ_RM,
		MOVB_MR, MOVW_MR, MOVL_MR, MOVQ_MR,
		ADD3, SUB3, ADC3, SBB3, TST, AND3, OR3, XOR3,
		MOV_RR, CF_BRA, CF_BSR, LDIX, MOV_IR
	} uCmd_t;

	// operand form, picks how fields map onto N/M/O and imm
	typedef enum logic [3:0] {
		FM_Z, FM_INV,
		FM_REGSTREG, FM_REGSTDRREG, FM_LDREGREG, FM_LDDRREGREG,
		FM_REGREG3, FM_REGREG, FM_PCDISP8,
		FM_IMM8Z, FM_IMM8N, FM_IMM12Z, FM_IMM12N, FM_IMM8REG
	} fmid_t;

	typedef enum logic [2:0] {SB = 3'd0, SW = 3'd1, SL = 3'd2, SQ = 3'd3} bty_t;

	// branch condition, always / if T set / if T clear
	typedef enum logic [1:0] {AL = 2'd0, CT = 2'd2, CF = 2'd3} ccty_t;

	// memory access mode in uIxt bits 5:4
	localparam logic [1:0] ixRri = 2'b01;
	// ALU carry-in variants
	localparam uIxt_t ixLdsb = 8'h00;
	localparam uIxt_t ixLdub = 8'h04;

	typedef struct packed {
		uCmd_t uCmd;
		fmid_t fmid;
		bty_t bty;
		ccty_t ccty;
		uIxt_t cmdIx;
	} opClass_s;

	typedef struct packed {
		regId_t rn;
		regId_t rm;
		regId_t ro;
		regId_t baseRn;
		regId_t baseRm;
		logic rnLow;
		logic rmLow;
	} regFields_s;

	typedef struct packed {
		imm_t imm8s;
		imm_t imm8z;
		imm_t imm8n;
		imm_t imm12z;
		imm_t imm12n;
	} immFields_s;

	typedef struct packed {
		uCmd_t uCmd;
		regId_t regN;
		regId_t regM;
		regId_t regO;
		imm_t imm;
		uIxt_t uIxt;
	} microOp_s;

endpackage

//--- logic/opClassifier.sv
`timescale 1ns/1ps

module opClassifier (
	input logic clock,
	input logic rstN,
	input logic take,
	input decodePkg::instr_t instrWord,
	output decodePkg::opClass_s cls,
	output logic clsValid
);

	decodePkg::opClass_s nextCls;

	always_comb begin
		nextCls.uCmd = decodePkg::INVOP;
		nextCls.fmid = decodePkg::FM_INV;
		nextCls.bty = decodePkg::SB;
		nextCls.ccty = decodePkg::AL;
		nextCls.cmdIx = '0;

		casez (instrWord[15:8])
			8'h0?: begin
				// bit 11 picks load over store, bit 10 the indexed form, 9:8 the size
				nextCls.bty = decodePkg::bty_t'({1'b0, instrWord[9:8]});
				case (instrWord[11:10])
					2'b00: nextCls.fmid = decodePkg::FM_REGSTREG;
					2'b01: nextCls.fmid = decodePkg::FM_REGSTDRREG;
					2'b10: nextCls.fmid = decodePkg::FM_LDREGREG;
					default: nextCls.fmid = decodePkg::FM_LDDRREGREG;
				endcase
				case (instrWord[9:8])
					2'd0: nextCls.uCmd = instrWord[11] ? decodePkg::MOVB_MR : decodePkg::MOVB_RM;
					2'd1: nextCls.uCmd = instrWord[11] ? decodePkg::MOVW_MR : decodePkg::MOVW_RM;
					2'd2: nextCls.uCmd = instrWord[11] ? decodePkg::MOVL_MR : decodePkg::MOVL_RM;
					default: nextCls.uCmd = instrWord[11] ? decodePkg::MOVQ_MR : decodePkg::MOVQ_RM;
				endcase
				// all-zero word would otherwise be a byte store of R0 to R0
				if (instrWord == 16'h0000) begin
					nextCls.uCmd = decodePkg::NOP;
					nextCls.fmid = decodePkg::FM_Z;
				end
			end

			// three-operand ALU, Rn = Rn op Rm
			8'h10: begin
				nextCls.uCmd = decodePkg::ADD3;
				nextCls.fmid = decodePkg::FM_REGREG3;
				nextCls.cmdIx = decodePkg::ixLdsb;
			end
			8'h11: begin
				nextCls.uCmd = decodePkg::SUB3;
				nextCls.fmid = decodePkg::FM_REGREG3;
				nextCls.cmdIx = decodePkg::ixLdub;
			end
			8'h12: begin
				nextCls.uCmd = decodePkg::ADC3;
				nextCls.fmid = decodePkg::FM_REGREG3;
				nextCls.cmdIx = decodePkg::ixLdsb;
			end
			8'h13: begin
				nextCls.uCmd = decodePkg::SBB3;
				nextCls.fmid = decodePkg::FM_REGREG3;
				nextCls.cmdIx = decodePkg::ixLdub;
			end
			8'h14: begin
				nextCls.uCmd = decodePkg::TST;
				nextCls.fmid = decodePkg::FM_REGREG;
			end
			8'h15: begin
				nextCls.uCmd = decodePkg::AND3;
				nextCls.fmid = decodePkg::FM_REGREG3;
			end
			8'h16: begin
				nextCls.uCmd = decodePkg::OR3;
				nextCls.fmid = decodePkg::FM_REGREG3;
			end
			8'h17: begin
				nextCls.uCmd = decodePkg::XOR3;
				nextCls.fmid = decodePkg::FM_REGREG3;
			end
			8'h18: begin
				nextCls.uCmd = decodePkg::MOV_RR;
				nextCls.fmid = decodePkg::FM_REGREG;
			end

			// BT and BF are BRA with a condition attached
			8'b0010_00??: begin
				nextCls.uCmd = (instrWord[9:8] == 2'd1) ? decodePkg::CF_BSR : decodePkg::CF_BRA;
				nextCls.fmid = decodePkg::FM_PCDISP8;
				nextCls.bty = decodePkg::SW;
				if (instrWord[9:8] == 2'd2) begin
					nextCls.ccty = decodePkg::CT;
				end else if (instrWord[9:8] == 2'd3) begin
					nextCls.ccty = decodePkg::CF;
				end
			end

			8'h24: begin
				nextCls.uCmd = decodePkg::LDIX;
				nextCls.fmid = decodePkg::FM_IMM8Z;
			end
			8'h25: begin
				nextCls.uCmd = decodePkg::LDIX;
				nextCls.fmid = decodePkg::FM_IMM8N;
			end
			8'hA?: begin
				nextCls.uCmd = decodePkg::LDIX;
				nextCls.fmid = decodePkg::FM_IMM12Z;
			end
			8'hB?: begin
				nextCls.uCmd = decodePkg::LDIX;
				nextCls.fmid = decodePkg::FM_IMM12N;
			end

			// Rn in bits 11:8, imm8 sign-extended
			8'hC?: begin
				nextCls.uCmd = decodePkg::ADD3;
				nextCls.fmid = decodePkg::FM_IMM8REG;
				nextCls.cmdIx = decodePkg::ixLdsb;
			end
			8'hE?: begin
				nextCls.uCmd = decodePkg::MOV_IR;
				nextCls.fmid = decodePkg::FM_IMM8REG;
			end

			default: begin
				nextCls.uCmd = decodePkg::INVOP;
				nextCls.fmid = decodePkg::FM_INV;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			clsValid <= 1'b0;
		end else begin
			clsValid <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			cls <= nextCls;
		end
	end

	// nothing may leave the stage straight out of reset
	clsIdleAfterReset: assert property (@(posedge clock) !rstN |=> !clsValid);

endmodule

//--- logic/fieldExtract.sv
`timescale 1ns/1ps

`include "decoder_defines.svh"

module fieldExtract (
	input logic clock,
	input logic rstN,
	input logic take,
	input decodePkg::instr_t instrWord,
	output decodePkg::regFields_s regs,
	output decodePkg::immFields_s imms
);

	decodePkg::regFields_s nextRegs;
	decodePkg::immFields_s nextImms;

	always_comb begin
		nextRegs.rn = {{(`REG_W - 4){1'b0}}, instrWord[7:4]};
		nextRegs.rm = {{(`REG_W - 4){1'b0}}, instrWord[3:0]};
		nextRegs.ro = {{(`REG_W - 4){1'b0}}, instrWord[11:8]};

		// R0 and R1 as index base mean PC and GBR
		nextRegs.rnLow = (instrWord[7:5] == 3'b000);
		nextRegs.rmLow = (instrWord[3:1] == 3'b000);
		if (nextRegs.rnLow) begin
			nextRegs.baseRn = instrWord[4] ? decodePkg::regGbr : decodePkg::regPc;
		end else begin
			nextRegs.baseRn = nextRegs.rn;
		end
		if (nextRegs.rmLow) begin
			nextRegs.baseRm = instrWord[0] ? decodePkg::regGbr : decodePkg::regPc;
		end else begin
			nextRegs.baseRm = nextRegs.rm;
		end
	end

	always_comb begin
		nextImms.imm8s = {{(`IMM_W - 8){instrWord[7]}}, instrWord[7:0]};
		nextImms.imm8z = {{(`IMM_W - 8){1'b0}}, instrWord[7:0]};
		// ones-extended forms build negative constants
		nextImms.imm8n = {{(`IMM_W - 8){1'b1}}, instrWord[7:0]};
		nextImms.imm12z = {{(`IMM_W - 12){1'b0}}, instrWord[11:0]};
		nextImms.imm12n = {{(`IMM_W - 12){1'b1}}, instrWord[11:0]};
	end

	// candidates only move on a take outside reset
	always_ff @(posedge clock) begin
		if (rstN && take) begin
			regs <= nextRegs;
			imms <= nextImms;
		end
	end

endmodule

//--- logic/operandFormer.sv
`timescale 1ns/1ps

`include "decoder_defines.svh"

module operandFormer (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	output logic instrReady,
	output logic take,
	input logic creditReturn,
	input decodePkg::opClass_s cls,
	input logic clsValid,
	input decodePkg::regFields_s regs,
	input decodePkg::immFields_s imms,
	output logic uopValid,
	output decodePkg::microOp_s uop
);

	decodePkg::credit_t credits;
	decodePkg::microOp_s nextUop;

	// every item in flight holds a credit, so uop never stalls
	assign instrReady = (credits != '0);
	assign take = instrValid && instrReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			credits <= decodePkg::credit_t'(`DEC_CREDITS);
		end else if (take && !creditReturn) begin
			credits <= credits - decodePkg::credit_t'(1);
		end else if (creditReturn && !take) begin
			credits <= credits + decodePkg::credit_t'(1);
		end
	end

	always_comb begin
		nextUop.uCmd = cls.uCmd;
		nextUop.regN = decodePkg::regZzr;
		nextUop.regM = decodePkg::regZzr;
		nextUop.regO = decodePkg::regZzr;
		nextUop.imm = '0;
		nextUop.uIxt = '0;

		case (cls.fmid)
			// stores put the data register on N and the address on M
			decodePkg::FM_REGSTREG: begin
				nextUop.regN = regs.rm;
				nextUop.regM = regs.rn;
				nextUop.uIxt = {cls.ccty, decodePkg::ixRri, 1'b0, cls.bty};
			end
			decodePkg::FM_LDREGREG: begin
				nextUop.regN = regs.rn;
				nextUop.regM = regs.rm;
				nextUop.uIxt = {cls.ccty, decodePkg::ixRri, 1'b1, cls.bty};
			end
			// indexed by DLR, a PC or GBR base scales by byte
			decodePkg::FM_REGSTDRREG: begin
				nextUop.regN = regs.rm;
				nextUop.regM = regs.baseRn;
				nextUop.regO = decodePkg::regDlr;
				nextUop.uIxt = {cls.ccty, decodePkg::ixRri, 1'b0,
					(regs.rnLow ? decodePkg::SB : cls.bty)};
			end
			decodePkg::FM_LDDRREGREG: begin
				nextUop.regN = regs.rn;
				nextUop.regM = regs.baseRm;
				nextUop.regO = decodePkg::regDlr;
				nextUop.uIxt = {cls.ccty, decodePkg::ixRri, 1'b1,
					(regs.rmLow ? decodePkg::SB : cls.bty)};
			end
			decodePkg::FM_REGREG3: begin
				nextUop.regN = regs.rn;
				nextUop.regM = regs.rn;
				nextUop.regO = regs.rm;
				nextUop.uIxt = cls.cmdIx;
			end
			decodePkg::FM_REGREG: begin
				nextUop.regN = regs.rn;
				nextUop.regM = regs.rm;
				nextUop.regO = decodePkg::regDlr;
				nextUop.uIxt = cls.cmdIx;
			end
			// target is PC plus a word-scaled displacement
			decodePkg::FM_PCDISP8: begin
				nextUop.regN = decodePkg::regDlr;
				nextUop.regM = decodePkg::regPc;
				nextUop.regO = decodePkg::regImm;
				nextUop.imm = imms.imm8s;
				nextUop.uIxt = {cls.ccty, decodePkg::ixRri, 1'b1, decodePkg::SW};
			end
			decodePkg::FM_IMM8Z: begin
				nextUop.regN = decodePkg::regDlr;
				nextUop.regM = decodePkg::regImm;
				nextUop.imm = imms.imm8z;
			end
			decodePkg::FM_IMM8N: begin
				nextUop.regN = decodePkg::regDlr;
				nextUop.regM = decodePkg::regImm;
				nextUop.imm = imms.imm8n;
			end
			decodePkg::FM_IMM12Z: begin
				nextUop.regN = decodePkg::regDlr;
				nextUop.regM = decodePkg::regImm;
				nextUop.imm = imms.imm12z;
			end
			decodePkg::FM_IMM12N: begin
				nextUop.regN = decodePkg::regDlr;
				nextUop.regM = decodePkg::regImm;
				nextUop.imm = imms.imm12n;
			end
			decodePkg::FM_IMM8REG: begin
				nextUop.regN = regs.ro;
				nextUop.regM = decodePkg::regImm;
				nextUop.regO = regs.ro;
				nextUop.imm = imms.imm8s;
				nextUop.uIxt = cls.cmdIx;
			end
			// nop and invalid keep every selector on ZZR
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			uopValid <= 1'b0;
		end else begin
			uopValid <= clsValid;
		end
	end

	always_ff @(posedge clock) begin
		if (clsValid) begin
			uop <= nextUop;
		end
	end

	// consumer must not hand back more than it was given
	creditBound: assert property (@(posedge clock) disable iff (!rstN)
		credits <= decodePkg::credit_t'(`DEC_CREDITS));

	noReturnWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		!(creditReturn && (credits == decodePkg::credit_t'(`DEC_CREDITS))));

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input decodePkg::instr_t instrWord,
	output logic instrReady,
	output logic uopValid,
	output decodePkg::microOp_s uop,
	input logic creditReturn
);

	logic take;
	logic clsValid;
	decodePkg::opClass_s cls;
	decodePkg::regFields_s regs;
	decodePkg::immFields_s imms;

	// classifier and extractor both capture the word on take
	opClassifier classifier (
		.clock(clock),
		.rstN(rstN),
		.take(take),
		.instrWord(instrWord),
		.cls(cls),
		.clsValid(clsValid)
	);

	fieldExtract extractor (
		.clock(clock),
		.rstN(rstN),
		.take(take),
		.instrWord(instrWord),
		.regs(regs),
		.imms(imms)
	);

	operandFormer former (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.take(take),
		.creditReturn(creditReturn),
		.cls(cls),
		.clsValid(clsValid),
		.regs(regs),
		.imms(imms),
		.uopValid(uopValid),
		.uop(uop)
	);

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clock,
	output logic rstN
);

	// 8 ns period
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// reset held over the first 16 rising edges
	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

//--- dv/decodeRef.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

`include "decoder_defines.svh"

// index base for a register nibble, R0 and R1 stand for PC and GBR
function automatic decodePkg::regId_t indexBase(input logic [3:0] r);
	if (r == 4'd0) begin
		return decodePkg::regPc;
	end else if (r == 4'd1) begin
		return decodePkg::regGbr;
	end
	return decodePkg::regId_t'(r);
endfunction

// expected micro-op for one instruction word
function automatic decodePkg::microOp_s refDecode(input decodePkg::instr_t w);
	decodePkg::microOp_s u;
	decodePkg::regId_t rn;
	decodePkg::regId_t rm;
	decodePkg::regId_t ro;
	logic isLoad;
	logic indexed;
	logic [2:0] size;
	logic [1:0] cond;

	rn = decodePkg::regId_t'(w[7:4]);
	rm = decodePkg::regId_t'(w[3:0]);
	ro = decodePkg::regId_t'(w[11:8]);
	u.uCmd = decodePkg::INVOP;
	u.regN = decodePkg::regZzr;
	u.regM = decodePkg::regZzr;
	u.regO = decodePkg::regZzr;
	u.imm = '0;
	u.uIxt = '0;

	if (w == 16'h0000) begin
		u.uCmd = decodePkg::NOP;
	end else if (w[15:12] == 4'h0) begin
		isLoad = w[11];
		indexed = w[10];
		size = {1'b0, w[9:8]};
		// stores MOVB_RM..MOVQ_RM, then loads MOVB_MR..MOVQ_MR
		u.uCmd = decodePkg::uCmd_t'(int'(decodePkg::MOVB_RM) + int'({isLoad, w[9:8]}));
		if (isLoad) begin
			u.regN = rn;
			u.regM = indexed ? indexBase(w[3:0]) : rm;
			if (indexed && w[3:1] == 3'b000) begin
				size = 3'd0;
			end
		end else begin
			u.regN = rm;
			u.regM = indexed ? indexBase(w[7:4]) : rn;
			if (indexed && w[7:5] == 3'b000) begin
				size = 3'd0;
			end
		end
		if (indexed) begin
			u.regO = decodePkg::regDlr;
		end
		u.uIxt = {2'b00, 2'b01, isLoad, size};
	end else if (w[15:8] >= 8'h10 && w[15:8] <= 8'h18) begin
		case (w[11:8])
			4'h0: u.uCmd = decodePkg::ADD3;
			4'h1: u.uCmd = decodePkg::SUB3;
			4'h2: u.uCmd = decodePkg::ADC3;
			4'h3: u.uCmd = decodePkg::SBB3;
			4'h4: u.uCmd = decodePkg::TST;
			4'h5: u.uCmd = decodePkg::AND3;
			4'h6: u.uCmd = decodePkg::OR3;
			4'h7: u.uCmd = decodePkg::XOR3;
			default: u.uCmd = decodePkg::MOV_RR;
		endcase
		// subtracting forms use the unsigned variant
		if (w[11:8] == 4'h1 || w[11:8] == 4'h3) begin
			u.uIxt = 8'h04;
		end
		u.regN = rn;
		if (w[11:8] == 4'h4 || w[11:8] == 4'h8) begin
			u.regM = rm;
			u.regO = decodePkg::regDlr;
		end else begin
			u.regM = rn;
			u.regO = rm;
		end
	end else if (w[15:10] == 6'b001000) begin
		u.uCmd = (w[9:8] == 2'd1) ? decodePkg::CF_BSR : decodePkg::CF_BRA;
		cond = (w[9:8] == 2'd2) ? 2'd2 : ((w[9:8] == 2'd3) ? 2'd3 : 2'd0);
		u.regN = decodePkg::regDlr;
		u.regM = decodePkg::regPc;
		u.regO = decodePkg::regImm;
		u.imm = {{(`IMM_W - 8){w[7]}}, w[7:0]};
		u.uIxt = {cond, 2'b01, 1'b1, 3'd1};
	end else if (w[15:8] == 8'h24 || w[15:8] == 8'h25 || w[15:12] == 4'hA
			|| w[15:12] == 4'hB) begin
		u.uCmd = decodePkg::LDIX;
		u.regN = decodePkg::regDlr;
		u.regM = decodePkg::regImm;
		if (w[15:8] == 8'h24) begin
			u.imm = {{(`IMM_W - 8){1'b0}}, w[7:0]};
		end else if (w[15:8] == 8'h25) begin
			u.imm = {{(`IMM_W - 8){1'b1}}, w[7:0]};
		end else if (w[15:12] == 4'hA) begin
			u.imm = {{(`IMM_W - 12){1'b0}}, w[11:0]};
		end else begin
			u.imm = {{(`IMM_W - 12){1'b1}}, w[11:0]};
		end
	end else if (w[15:12] == 4'hC || w[15:12] == 4'hE) begin
		u.uCmd = (w[15:12] == 4'hC) ? decodePkg::ADD3 : decodePkg::MOV_IR;
		u.regN = ro;
		u.regM = decodePkg::regImm;
		u.regO = ro;
		u.imm = {{(`IMM_W - 8){w[7]}}, w[7:0]};
	end
	return u;
endfunction

`endif

//--- dv/instrDecoderTb.sv
`timescale 1ns/1ps

`include "decoder_defines.svh"

module instrDecoderTb;

	// sampling edges from the take edge to the edge that sees uopValid
	localparam int latency = 2;
	localparam int randCount = 2000;
	localparam int dirCount = 30;
	localparam int idxCount = 6;
	localparam int extCount = 12;
	localparam int totalOps = `DEC_CREDITS + dirCount + idxCount + extCount + randCount;

	logic clock;
	logic rstN;
	logic instrValid;
	decodePkg::instr_t instrWord;
	logic instrReady;
	logic uopValid;
	decodePkg::microOp_s uop;
	logic creditReturn;

	integer stimSeed = 5;
	integer returnSeed = 5;
	int errors = 0;
	int takeCount = 0;
	int uopCount = 0;
	int cycle = 0;
	int owed = 0;
	int waitLeft = 0;
	logic holdCredits = 1'b0;
	string testName = "reset";
	decodePkg::microOp_s expQ[$];
	int takeAtQ[$];
	string nameQ[$];
	decodePkg::microOp_s expUop;
	int takeAt;
	string takeName;

	decodePkg::instr_t dirWords [dirCount] = '{
		16'h0000, 16'h0123, 16'h0245, 16'h0367, 16'h0812, 16'h09AB, 16'h0ACD, 16'h0BEF,
		16'h10AB, 16'h1134, 16'h1256, 16'h1378, 16'h149A, 16'h15BC, 16'h16DE, 16'h17F0,
		16'h1821, 16'h2005, 16'h21F0, 16'h2280, 16'h237F, 16'h2412, 16'h25F3, 16'hA123,
		16'hB456, 16'hC312, 16'hE7A5, 16'h3000, 16'hF123, 16'h1900
	};
	// index register R0, R1 and R5 for stores and loads
	decodePkg::instr_t idxWords [idxCount] = '{
		16'h0602, 16'h0713, 16'h0653, 16'h0E30, 16'h0F41, 16'h0D65
	};
	decodePkg::instr_t extWords [extCount] = '{
		16'h2080, 16'h207F, 16'h2480, 16'h247F, 16'h2580, 16'h2501,
		16'hA800, 16'hA7FF, 16'hB800, 16'hB07F, 16'hC080, 16'hE47F
	};

	clockGen clocks (
		.clock(clock),
		.rstN(rstN)
	);

	instrDecoder UUT (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.instrReady(instrReady),
		.uopValid(uopValid),
		.uop(uop),
		.creditReturn(creditReturn)
	);

	`include "decodeRef.svh"

	task automatic compareUop(input string name, input decodePkg::microOp_s exp,
			input decodePkg::microOp_s act);
		if (act.uCmd !== exp.uCmd) begin
			errors++;
			$display("Fail %s uCmd expected %h actual %h", name, exp.uCmd, act.uCmd);
		end
		if (act.regN !== exp.regN) begin
			errors++;
			$display("Fail %s regN expected %h actual %h", name, exp.regN, act.regN);
		end
		if (act.regM !== exp.regM) begin
			errors++;
			$display("Fail %s regM expected %h actual %h", name, exp.regM, act.regM);
		end
		if (act.regO !== exp.regO) begin
			errors++;
			$display("Fail %s regO expected %h actual %h", name, exp.regO, act.regO);
		end
		if (act.imm !== exp.imm) begin
			errors++;
			$display("Fail %s imm expected %h actual %h", name, exp.imm, act.imm);
		end
		if (act.uIxt !== exp.uIxt) begin
			errors++;
			$display("Fail %s uIxt expected %h actual %h", name, exp.uIxt, act.uIxt);
		end
	endtask

	// holds the word until the edge that takes it
	task automatic sendWord(input decodePkg::instr_t w);
		instrValid <= 1'b1;
		instrWord <= w;
		@(posedge clock);
		while (!instrReady) begin
			@(posedge clock);
		end
		instrValid <= 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0 || owed != 0) begin
			@(negedge clock);
		end
		repeat (3) @(posedge clock);
	endtask

	// takes queue the expected micro-op, uopValid pops and compares
	always @(posedge clock) begin
		cycle++;
		if (rstN) begin
			if (instrValid && instrReady) begin
				expQ.push_back(refDecode(instrWord));
				takeAtQ.push_back(cycle);
				nameQ.push_back($sformatf("%s word %h", testName, instrWord));
				takeCount++;
			end
			if (uopValid) begin
				uopCount++;
				if (expQ.size() == 0) begin
					errors++;
					$display("uopValid went high with no instruction word outstanding");
				end else begin
					expUop = expQ.pop_front();
					takeAt = takeAtQ.pop_front();
					takeName = nameQ.pop_front();
					compareUop(takeName, expUop, uop);
					if (cycle - takeAt != latency) begin
						errors++;
						$display("Fail %s latency expected %0d actual %0d", takeName,
							latency, cycle - takeAt);
					end
				end
			end
		end
	end

	// frees each micro-op after 0 to 7 cycles, one credit per cycle at most
	always @(posedge clock) begin
		if (!rstN) begin
			creditReturn <= 1'b0;
			owed = 0;
			waitLeft = 0;
		end else begin
			if (uopValid) begin
				owed++;
			end
			if (owed > 0 && waitLeft == 0 && !holdCredits) begin
				creditReturn <= 1'b1;
				owed--;
				waitLeft = $random(returnSeed) & 7;
			end else begin
				creditReturn <= 1'b0;
				if (waitLeft > 0) begin
					waitLeft--;
				end
			end
		end
	end

	initial begin
		int startTakes;

		instrValid = 1'b0;
		instrWord = '0;
		creditReturn = 1'b0;
		wait (rstN === 1'b1);
		@(posedge clock);
		if (instrReady !== 1'b1) begin
			errors++;
			$display("Fail reset instrReady expected 1 actual %b", instrReady);
		end
		if (uopValid !== 1'b0) begin
			errors++;
			$display("Fail reset uopValid expected 0 actual %b", uopValid);
		end

		// no credits come back, so only the reset credits can be spent
		testName <= "credits";
		holdCredits <= 1'b1;
		startTakes = takeCount;
		instrValid <= 1'b1;
		instrWord <= 16'h1234;
		repeat (`DEC_CREDITS + 4) @(posedge clock);
		instrValid <= 1'b0;
		@(posedge clock);
		if (takeCount - startTakes != `DEC_CREDITS) begin
			errors++;
			$display("Fail credits takes expected %0d actual %0d", `DEC_CREDITS,
				takeCount - startTakes);
		end
		if (instrReady !== 1'b0) begin
			errors++;
			$display("Fail credits instrReady expected 0 actual %b", instrReady);
		end
		holdCredits <= 1'b0;
		waitDrain();

		testName <= "directed";
		foreach (dirWords[i]) begin
			sendWord(dirWords[i]);
		end
		testName <= "indexed";
		foreach (idxWords[i]) begin
			sendWord(idxWords[i]);
		end
		testName <= "extension";
		foreach (extWords[i]) begin
			sendWord(extWords[i]);
		end
		waitDrain();

		testName <= "random";
		for (int i = 0; i < randCount; i++) begin
			sendWord(16'($random(stimSeed)));
			if (($random(stimSeed) & 3) == 0) begin
				repeat (($random(stimSeed) & 7) + 1) @(posedge clock);
			end
		end
		waitDrain();

		if (instrReady !== 1'b1) begin
			errors++;
			$display("credits were not all restored, instrReady is low after the drain");
		end
		if (takeCount != uopCount) begin
			errors++;
			$display("Fail count micro-ops expected %0d actual %0d", takeCount, uopCount);
		end
		$display("errors %0d, takes %0d, micro-ops %0d", errors, takeCount, uopCount);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// about 12 cycles per op plus reset and drain slack
	initial begin
		repeat (totalOps * 12 + 200) @(posedge clock);
		$display("timeout after %0d cycles, the decoder stopped making progress",
			totalOps * 12 + 200);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- all.f
+incdir+logic
+incdir+dv
logic/decodePkg.sv
logic/opClassifier.sv
logic/fieldExtract.sv
logic/operandFormer.sv
logic/instrDecoder.sv
dv/clockGen.sv
dv/instrDecoderTb.sv
